/* logic/muldiv_pkg.sv */
`default_nettype none

package muldiv_pkg;

	// operand width of the unit.
	localparam int DATA_W = 32;

	// op codes, written to bits 3:0 of the op register.
	typedef enum logic [3:0] {
		OP_MULT  = 4'd0,
		OP_MULTU = 4'd1,
		OP_MADD  = 4'd2,
		OP_MADDU = 4'd3,
		OP_MSUB  = 4'd4,
		OP_MSUBU = 4'd5,
		OP_DIV   = 4'd6,
		OP_DIVU  = 4'd7,
		OP_MTHI  = 4'd8,
		OP_MTLO  = 4'd9
	} muldiv_op_e;

	// word addresses on the bus.
	typedef enum logic [2:0] {
		REG_A  = 3'd0,
		REG_B  = 3'd1,
		REG_OP = 3'd2,
		REG_LO = 3'd3,
		REG_HI = 3'd4
	} reg_addr_e;

	// hi/lo pair, seen as one word or as two halves.
	typedef union packed {
		logic [2*DATA_W-1:0] full;
		struct packed {
			logic [DATA_W-1:0] hi;
			logic [DATA_W-1:0] lo;
		} half;
	} hilo_u;

endpackage

`default_nettype wire

/* logic/muldiv_if.sv */
`timescale 1ns/1ps
`default_nettype none

// command from the bus side to the datapath.
interface cmd_if;
	logic                          valid;
	muldiv_pkg::muldiv_op_e        op;
	logic [muldiv_pkg::DATA_W-1:0] a;
	logic [muldiv_pkg::DATA_W-1:0] b;

	modport issue (output valid, op, a, b);
	modport execute (input valid, op, a, b);
endinterface

// sign-corrected result toward the hi/lo register.
interface res_if;
	logic                            valid;
	muldiv_pkg::muldiv_op_e          op;
	logic [2*muldiv_pkg::DATA_W-1:0] value;

	modport produce (output valid, op, value);
	modport store (input valid, op, value);
endinterface

`default_nettype wire

/* logic/muldiv_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_mult (
	input  logic                            clk,
	input  logic                            start,
	input  logic [muldiv_pkg::DATA_W-1:0]   x,
	input  logic [muldiv_pkg::DATA_W-1:0]   y,
	output logic [2*muldiv_pkg::DATA_W-1:0] product,
	output logic                            ready
);

	localparam int W = muldiv_pkg::DATA_W;
	localparam int H = W / 2;

	logic [W-1:0] x_hi, x_lo, y_hi, y_lo;
	logic [W-1:0] pp_hi, pp_lo;
	logic [W:0]   pp_md;
	logic         stage1_v;

	// halves zero-extended to full width.
	assign x_hi = {{H{1'b0}}, x[W-1:H]};
	assign x_lo = {{H{1'b0}}, x[H-1:0]};
	assign y_hi = {{H{1'b0}}, y[W-1:H]};
	assign y_lo = {{H{1'b0}}, y[H-1:0]};

	always_ff @(posedge clk) begin
		// stage one, partial products.
		pp_hi <= x_hi * y_hi;
		pp_lo <= x_lo * y_lo;
		pp_md <= {1'b0, x_lo * y_hi} + {1'b0, x_hi * y_lo};
		stage1_v <= start;
		// stage two, middle term shifted into place.
		product <= {pp_hi, pp_lo} + {{(H-1){1'b0}}, pp_md, {H{1'b0}}};
		ready <= stage1_v;
	end

endmodule

`default_nettype wire

/* logic/muldiv_div.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_div #(
	parameter int DIV_STEPS = 32
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  logic [muldiv_pkg::DATA_W-1:0] dividend,
	input  logic [muldiv_pkg::DATA_W-1:0] divisor,
	output logic [muldiv_pkg::DATA_W-1:0] quotient,
	output logic [muldiv_pkg::DATA_W-1:0] remainder,
	output logic                          ready
);

	localparam int W = muldiv_pkg::DATA_W;
	localparam int CNT_W = $clog2(DIV_STEPS + 1);

	logic [CNT_W-1:0] count;
	logic [W-1:0]     rem_q;
	logic [W-1:0]     quo_q;
	logic [W-1:0]     den_q;
	logic [W:0]       shifted;
	logic [W:0]       trial;

	// next dividend bit enters the partial remainder.
	assign shifted = {rem_q, quo_q[W-1]};
	assign trial = shifted - {1'b0, den_q};

	assign quotient = quo_q;
	assign remainder = rem_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
			ready <= 1'b0;
		end else begin
			ready <= (count == CNT_W'(1));
			if (start) begin
				count <= CNT_W'(DIV_STEPS);
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem_q <= '0;
			// top bits of a short dividend shift out first.
			quo_q <= dividend << (W - DIV_STEPS);
			den_q <= divisor;
		end else if (count != '0) begin
			// restore on a negative trial.
			if (trial[W]) begin
				rem_q <= shifted[W-1:0];
			end else begin
				rem_q <= trial[W-1:0];
			end
			quo_q <= {quo_q[W-2:0], ~trial[W]};
		end
	end

endmodule

`default_nettype wire

/* logic/muldiv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_execute #(
	parameter int DIV_STEPS = 32
) (
	input  logic   clk,
	input  logic   rst_n,
	cmd_if.execute cmd,
	res_if.produce res
);

	localparam int W = muldiv_pkg::DATA_W;

	logic                   is_signed, is_mul, is_div, move_now;
	logic [W-1:0]           abs_a, abs_b;
	muldiv_pkg::muldiv_op_e op_q;
	logic                   neg_q, neg_rem_q;
	logic [2*W-1:0]         product, prod_fix;
	logic                   mult_ready;
	logic [W-1:0]           quo, rem;
	logic                   div_ready;

	always_comb begin
		is_signed = 1'b0;
		is_mul = 1'b0;
		is_div = 1'b0;
		case (cmd.op)
			muldiv_pkg::OP_MULT, muldiv_pkg::OP_MADD, muldiv_pkg::OP_MSUB: begin
				is_signed = 1'b1;
				is_mul = 1'b1;
			end
			muldiv_pkg::OP_MULTU, muldiv_pkg::OP_MADDU, muldiv_pkg::OP_MSUBU: is_mul = 1'b1;
			muldiv_pkg::OP_DIV: begin
				is_signed = 1'b1;
				is_div = 1'b1;
			end
			muldiv_pkg::OP_DIVU: is_div = 1'b1;
			default: ;
		endcase
	end

	assign abs_a = (is_signed && cmd.a[W-1]) ? -cmd.a : cmd.a;
	assign abs_b = (is_signed && cmd.b[W-1]) ? -cmd.b : cmd.b;
	assign move_now = cmd.valid & ~is_mul & ~is_div;

	// sign info held until the unit finishes.
	always_ff @(posedge clk) begin
		if (cmd.valid) begin
			op_q <= cmd.op;
			neg_q <= is_signed & (cmd.a[W-1] ^ cmd.b[W-1]);
			neg_rem_q <= is_signed & cmd.a[W-1];
		end
	end

	muldiv_mult u_mult (
		.clk     (clk),
		.start   (cmd.valid & is_mul),
		.x       (abs_a),
		.y       (abs_b),
		.product (product),
		.ready   (mult_ready)
	);

	muldiv_div #(
		.DIV_STEPS (DIV_STEPS)
	) u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (cmd.valid & is_div),
		.dividend  (abs_a),
		.divisor   (abs_b),
		.quotient  (quo),
		.remainder (rem),
		.ready     (div_ready)
	);

	assign prod_fix = neg_q ? -product : product;

	assign res.valid = mult_ready | div_ready | move_now;
	assign res.op = move_now ? cmd.op : op_q;

	always_comb begin
		if (mult_ready) begin
			res.value = prod_fix;
		end else if (div_ready) begin
			// remainder follows the dividend sign.
			res.value = {neg_rem_q ? -rem : rem, neg_q ? -quo : quo};
		end else if (cmd.op == muldiv_pkg::OP_MTHI) begin
			res.value = {cmd.a, {W{1'b0}}};
		end else begin
			res.value = {{W{1'b0}}, cmd.a};
		end
	end

endmodule

`default_nettype wire

/* logic/muldiv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_result (
	input  logic              clk,
	input  logic              rst_n,
	res_if.store              res,
	output muldiv_pkg::hilo_u hilo,
	output logic              done
);

	localparam int W = muldiv_pkg::DATA_W;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hilo.full <= '0;
			done <= 1'b0;
		end else begin
			done <= res.valid;
			if (res.valid) begin
				case (res.op)
					// accumulate on the whole 64-bit pair.
					muldiv_pkg::OP_MADD, muldiv_pkg::OP_MADDU: begin
						hilo.full <= hilo.full + res.value;
					end
					muldiv_pkg::OP_MSUB, muldiv_pkg::OP_MSUBU: begin
						hilo.full <= hilo.full - res.value;
					end
					muldiv_pkg::OP_MULT, muldiv_pkg::OP_MULTU,
					muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU: begin
						hilo.full <= res.value;
					end
					// moves touch one half only.
					muldiv_pkg::OP_MTHI: hilo.half.hi <= res.value[2*W-1:W];
					muldiv_pkg::OP_MTLO: hilo.half.lo <= res.value[W-1:0];
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* logic/muldiv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_decode (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cyc,
	input  logic                          stb,
	input  logic                          we,
	input  logic [2:0]                    adr,
	input  logic [muldiv_pkg::DATA_W-1:0] dat_w,
	output logic [muldiv_pkg::DATA_W-1:0] dat_r,
	output logic                          ack,
	cmd_if.issue                          cmd,
	input  muldiv_pkg::hilo_u             hilo,
	input  logic                          done
);

	localparam int W = muldiv_pkg::DATA_W;

	muldiv_pkg::reg_addr_e addr;
	logic                  req;
	logic                  new_req;
	logic                  is_cmd;
	logic                  ack_q;
	logic                  busy;
	logic [W-1:0]          a_q;
	logic [W-1:0]          b_q;

	assign addr = muldiv_pkg::reg_addr_e'(adr);
	assign req = cyc & stb;
	// command writes complete when the result side reports done.
	assign ack = req & (ack_q | (busy & done));
	assign new_req = req & ~ack & ~busy;
	assign is_cmd = we & (addr == muldiv_pkg::REG_OP || addr == muldiv_pkg::REG_LO ||
		addr == muldiv_pkg::REG_HI);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			busy <= 1'b0;
			cmd.valid <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			cmd.valid <= 1'b0;
			if (busy && done) begin
				busy <= 1'b0;
			end
			if (new_req) begin
				if (is_cmd) begin
					busy <= 1'b1;
					cmd.valid <= 1'b1;
				end else begin
					ack_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (new_req && we) begin
			case (addr)
				muldiv_pkg::REG_A: a_q <= dat_w;
				muldiv_pkg::REG_B: b_q <= dat_w;
				muldiv_pkg::REG_OP: begin
					cmd.op <= muldiv_pkg::muldiv_op_e'(dat_w[3:0]);
					cmd.a <= a_q;
					cmd.b <= b_q;
				end
				// moves carry the bus word as operand a.
				muldiv_pkg::REG_LO: begin
					cmd.op <= muldiv_pkg::OP_MTLO;
					cmd.a <= dat_w;
				end
				muldiv_pkg::REG_HI: begin
					cmd.op <= muldiv_pkg::OP_MTHI;
					cmd.a <= dat_w;
				end
				default: ;
			endcase
		end else if (new_req) begin
			case (addr)
				muldiv_pkg::REG_A:  dat_r <= a_q;
				muldiv_pkg::REG_B:  dat_r <= b_q;
				muldiv_pkg::REG_LO: dat_r <= hilo.half.lo;
				muldiv_pkg::REG_HI: dat_r <= hilo.half.hi;
				default:            dat_r <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/muldiv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_top #(
	parameter int DIV_STEPS = 32
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cyc,
	input  logic                          stb,
	input  logic                          we,
	input  logic [2:0]                    adr,
	input  logic [muldiv_pkg::DATA_W-1:0] dat_w,
	output logic [muldiv_pkg::DATA_W-1:0] dat_r,
	output logic                          ack
);

	muldiv_pkg::hilo_u hilo;
	logic              done;

	cmd_if cmd_bus ();
	res_if res_bus ();

	muldiv_decode u_decode (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack),
		.cmd   (cmd_bus),
		.hilo  (hilo),
		.done  (done)
	);

	muldiv_execute #(
		.DIV_STEPS (DIV_STEPS)
	) u_execute (
		.clk   (clk),
		.rst_n (rst_n),
		.cmd   (cmd_bus),
		.res   (res_bus)
	);

	muldiv_result u_result (
		.clk   (clk),
		.rst_n (rst_n),
		.res   (res_bus),
		.hilo  (hilo),
		.done  (done)
	);

endmodule

`default_nettype wire

/* dv/muldiv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_checker (
	input logic        clk,
	input logic        rst_n,
	input logic        cyc,
	input logic        stb,
	input logic        ack,
	input logic        done,
	input logic        cmd_valid,
	input logic [63:0] hilo
);

	// count of failed assertions.
	int unsigned fail_count = 0;

	// set by an issue, cleared by the matching done.
	logic outstanding;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			outstanding <= 1'b0;
		end else if (cmd_valid) begin
			outstanding <= 1'b1;
		end else if (done) begin
			outstanding <= 1'b0;
		end
	end

	// never acknowledged in the cycle a request first appears.
	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> (cyc && stb && $past(cyc && stb)))
		else begin
			$error("ack outside a sampled bus request");
			fail_count = fail_count + 1;
		end

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else begin
			$error("ack held longer than one cycle");
			fail_count = fail_count + 1;
		end

	// issue only when the previous command has reported done.
	issue_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |-> !outstanding)
		else begin
			$error("command issued while another is outstanding");
			fail_count = fail_count + 1;
		end

	hilo_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(hilo))
		else begin
			$error("hi/lo register holds unknown bits");
			fail_count = fail_count + 1;
		end

endmodule

bind muldiv_decode muldiv_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.cyc       (cyc),
	.stb       (stb),
	.ack       (ack),
	.done      (done),
	.cmd_valid (cmd.valid),
	.hilo      (hilo)
);

`default_nettype wire

/* dv/muldiv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;

	localparam int DIV_STEPS = 32;
	// upper bound on bus transfers over all tests.
	localparam int N_XFERS = 400;
	localparam int TIMEOUT_CYCLES = N_XFERS * (DIV_STEPS + 10) + 1000;

	logic        clk;
	logic        rst_n;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [2:0]  adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic        ack;

	logic [31:0] rng;
	logic [63:0] exp_hilo;
	logic [63:0] ack_hilo;
	int          ack_waits;
	logic        cmp_req = 1'b0;
	int          checks = 0;
	int          errors = 0;
	int          test_checks = 0;
	int          test_errors = 0;

	muldiv_top #(
		.DIV_STEPS (DIV_STEPS)
	) dut (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic rand_word(output logic [31:0] v);
		rng = xorshift32(rng);
		v = rng;
	endtask

	// expected hi/lo after one operation.
	function automatic logic [63:0] model_op(input muldiv_pkg::muldiv_op_e op,
		input logic [31:0] a, input logic [31:0] b, input logic [63:0] hilo);
		logic [63:0] sprod;
		logic [63:0] uprod;
		longint      sa;
		longint      sb;
		longint      q;
		longint      r;
		logic [63:0] next;
		sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
		uprod = {32'd0, a} * {32'd0, b};
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		// truncating division, remainder takes the dividend sign.
		q = sa / sb;
		r = sa % sb;
		next = hilo;
		case (op)
			muldiv_pkg::OP_MULT:  next = sprod;
			muldiv_pkg::OP_MULTU: next = uprod;
			muldiv_pkg::OP_MADD:  next = hilo + sprod;
			muldiv_pkg::OP_MADDU: next = hilo + uprod;
			muldiv_pkg::OP_MSUB:  next = hilo - sprod;
			muldiv_pkg::OP_MSUBU: next = hilo - uprod;
			muldiv_pkg::OP_DIV:   next = {r[31:0], q[31:0]};
			muldiv_pkg::OP_DIVU:  next = {a % b, a / b};
			muldiv_pkg::OP_MTHI:  next = {a, hilo[31:0]};
			muldiv_pkg::OP_MTLO:  next = {hilo[63:32], a};
			default: ;
		endcase
		return next;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// one classic cycle, held until ack.
	task automatic wb_access(input logic write, input logic [2:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		ack_waits = 0;
		@(negedge clk);
		while (!ack) begin
			ack_waits++;
			@(negedge clk);
		end
		rdata = dat_r;
		ack_hilo = dut.hilo;
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		wb_access(1'b1, addr, data, ignored);
	endtask

	task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
		wb_access(1'b0, addr, 32'd0, data);
	endtask

	task automatic request_compare();
		cmp_req = 1'b1;
		wait (cmp_req == 1'b0);
	endtask

	task automatic run_op(input muldiv_pkg::muldiv_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		wb_write(muldiv_pkg::REG_A, a);
		wb_write(muldiv_pkg::REG_B, b);
		wb_write(muldiv_pkg::REG_OP, {28'd0, op});
		exp_hilo = model_op(op, a, b, exp_hilo);
		request_compare();
	endtask

	task automatic run_move(input logic to_hi, input logic [31:0] v);
		if (to_hi) begin
			wb_write(muldiv_pkg::REG_HI, v);
			exp_hilo = model_op(muldiv_pkg::OP_MTHI, v, 32'd0, exp_hilo);
		end else begin
			wb_write(muldiv_pkg::REG_LO, v);
			exp_hilo = model_op(muldiv_pkg::OP_MTLO, v, 32'd0, exp_hilo);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks - test_checks,
			errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	// reads hi and lo back whenever the stimulus asks.
	initial begin : compare
		logic [31:0] hi;
		logic [31:0] lo;
		forever begin
			wait (cmp_req == 1'b1);
			wb_read(muldiv_pkg::REG_HI, hi);
			wb_read(muldiv_pkg::REG_LO, lo);
			check_value("hi", {32'd0, hi}, {32'd0, exp_hilo[63:32]});
			check_value("lo", {32'd0, lo}, {32'd0, exp_hilo[31:0]});
			cmp_req = 1'b0;
		end
	end

	initial begin : stimulus
		logic [31:0]            a;
		logic [31:0]            b;
		logic [31:0]            v;
		logic [31:0]            corners [3];
		muldiv_pkg::muldiv_op_e op;
		int unsigned            fails;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 3'd0;
		dat_w = 32'd0;
		rng = 32'd17;
		exp_hilo = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		request_compare();
		for (int i = 0; i < 4; i++) begin
			rand_word(a);
			rand_word(b);
			run_move(1'b1, a);
			run_move(1'b0, b);
			request_compare();
		end
		end_test("moves");

		corners = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000};
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				run_op(muldiv_pkg::OP_MULT, corners[i], corners[j]);
				run_op(muldiv_pkg::OP_MULTU, corners[i], corners[j]);
			end
		end
		for (int i = 0; i < 8; i++) begin
			rand_word(a);
			rand_word(b);
			run_op(muldiv_pkg::OP_MULT, a, b);
			run_op(muldiv_pkg::OP_MULTU, b, a);
		end
		end_test("multiply");

		rand_word(a);
		rand_word(b);
		run_move(1'b1, a);
		run_move(1'b0, b);
		for (int i = 0; i < 12; i++) begin
			rand_word(a);
			rand_word(b);
			rand_word(v);
			// ops 2 to 5 are the accumulate group.
			op = muldiv_pkg::muldiv_op_e'(4'd2 + {2'b00, v[1:0]});
			run_op(op, a, b);
		end
		end_test("accumulate");

		for (int i = 0; i < 20; i++) begin
			rand_word(a);
			rand_word(b);
			rand_word(v);
			b = b >> v[4:0];
			if (b == 32'd0) begin
				b = 32'd1;
			end
			run_op(v[5] ? muldiv_pkg::OP_DIVU : muldiv_pkg::OP_DIV, a, b);
		end
		run_op(muldiv_pkg::OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
		run_op(muldiv_pkg::OP_DIV, 32'hFFFF_FFF9, 32'd2);
		run_op(muldiv_pkg::OP_DIVU, 32'hFFFF_FFFF, 32'd16);
		end_test("divide");

		// result must already be stored when the divide is acknowledged.
		rand_word(a);
		rand_word(b);
		b = (b >> 8) | 32'd1;
		wb_write(muldiv_pkg::REG_A, a);
		wb_write(muldiv_pkg::REG_B, b);
		exp_hilo = model_op(muldiv_pkg::OP_DIV, a, b, exp_hilo);
		wb_write(muldiv_pkg::REG_OP, {28'd0, muldiv_pkg::OP_DIV});
		check_value("hilo_at_ack", ack_hilo, exp_hilo);
		checks++;
		if (ack_waits == 0) begin
			errors++;
			$display("ERROR the divide was acknowledged without any wait states");
		end
		wb_read(muldiv_pkg::REG_HI, v);
		check_value("hi", {32'd0, v}, {32'd0, exp_hilo[63:32]});
		end_test("backpressure");

		fails = dut.u_decode.u_checker.fail_count;
		errors += int'(fails);
		$display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors, fails);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
logic/muldiv_pkg.sv
logic/muldiv_if.sv
logic/muldiv_mult.sv
logic/muldiv_div.sv
logic/muldiv_execute.sv
logic/muldiv_result.sv
logic/muldiv_decode.sv
logic/muldiv_top.sv
dv/muldiv_checker.sv
dv/muldiv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module muldiv_tb -f files.f || exit 1

out="$(./obj_dir/Vmuldiv_tb +verilator+error+limit+1000)"
echo "$out"
grep -qx "Simulation passed" <<< "$out" && exit 0 || exit 1
